// ==== hdl/inflate_pkg.sv ====
package inflate_pkg;

    // Nibbles 0..15 plus the end of block symbol
    localparam int num_symbols  = 17;
    localparam int sym_end      = 16;

    // Header layout
    localparam int len_bits     = 3;
    localparam int max_code_len = 7;
    localparam int header_bytes = 7;

    typedef logic [4:0] sym_t;

    // Zero marks an unused symbol
    typedef logic [2:0] len_t;

    typedef logic [6:0] code_t;

    typedef enum logic [1:0] {
        phase_idle,
        phase_header,
        phase_build,
        phase_decode
    } phase_e;

    // Canonical decode table indexed by code length
    typedef struct packed {
        sym_t  [max_code_len:1]  count;
        code_t [max_code_len:1]  first;
        sym_t  [max_code_len:1]  offset;
        sym_t  [num_symbols-1:0] symbols;
    } huff_table_s;

    typedef struct packed {
        logic valid;
        sym_t sym;
    } sym_beat_s;

endpackage

// ==== hdl/length_unpacker.sv ====
module length_unpacker (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              active,
    input  logic [7:0]        data_in,
    input  logic              data_in_vld,
    output logic              in_rdy,
    output logic              len_valid,
    output inflate_pkg::len_t len,
    output logic              header_done
);

    logic [9:0]        buffer;
    logic [3:0]        fill;
    inflate_pkg::sym_t len_cnt;
    logic [2:0]        byte_cnt;
    logic              load;
    logic              all_lens;

    assign all_lens = len_cnt == inflate_pkg::sym_t'(inflate_pkg::num_symbols);

    // Only take a byte once the buffer can no longer yield a length
    assign in_rdy = active && (fill < inflate_pkg::len_bits)
                    && (byte_cnt < inflate_pkg::header_bytes);
    assign load   = in_rdy && data_in_vld;

    assign len_valid   = active && (fill >= inflate_pkg::len_bits) && !all_lens;
    assign len         = buffer[inflate_pkg::len_bits-1:0];

    // Padding of the last byte is simply dropped when the phase ends
    assign header_done = active && all_lens && (byte_cnt == inflate_pkg::header_bytes);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buffer   <= '0;
            fill     <= '0;
            len_cnt  <= '0;
            byte_cnt <= '0;
        end else if (!active) begin
            buffer   <= '0;
            fill     <= '0;
            len_cnt  <= '0;
            byte_cnt <= '0;
        end else if (len_valid) begin
            buffer  <= buffer >> inflate_pkg::len_bits;
            fill    <= fill - 4'(inflate_pkg::len_bits);
            len_cnt <= len_cnt + 1'b1;
        end else if (load) begin
            buffer   <= buffer | (10'(data_in) << fill);
            fill     <= fill + 4'd8;
            byte_cnt <= byte_cnt + 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) fill <= 4'd10)
        else $error("length_unpacker: fill pointer above 10");

endmodule

// ==== hdl/huff_table_gen.sv ====
module huff_table_gen (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     len_valid,
    input  inflate_pkg::len_t        len,
    input  logic                     header_done,
    output inflate_pkg::huff_table_s huff_table,
    output logic                     tables_done
);

    inflate_pkg::len_t  lens [inflate_pkg::num_symbols];
    inflate_pkg::sym_t  wr_idx;

    logic               busy;
    inflate_pkg::len_t  scan_len;
    inflate_pkg::sym_t  scan_sym;
    inflate_pkg::sym_t  run_cnt;
    inflate_pkg::sym_t  run_ofs;
    inflate_pkg::code_t run_code;

    logic               hit;
    logic               last_sym;
    inflate_pkg::sym_t  cnt_next;

    assign hit      = lens[scan_sym] == scan_len;
    assign last_sym = scan_sym == inflate_pkg::sym_t'(inflate_pkg::num_symbols - 1);
    assign cnt_next = run_cnt + inflate_pkg::sym_t'(hit);

    always_ff @(posedge clk) begin
        if (len_valid && (wr_idx < inflate_pkg::num_symbols)) begin
            lens[wr_idx] <= len;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_idx <= '0;
        end else if (header_done) begin
            wr_idx <= '0;
        end else if (len_valid) begin
            wr_idx <= wr_idx + 1'b1;
        end
    end

    // One symbol per cycle, lengths 1 to 7 in turn
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy        <= 1'b0;
            scan_len    <= '0;
            scan_sym    <= '0;
            run_cnt     <= '0;
            run_ofs     <= '0;
            run_code    <= '0;
            tables_done <= 1'b0;
        end else begin
            tables_done <= 1'b0;
            if (header_done) begin
                busy     <= 1'b1;
                scan_len <= inflate_pkg::len_t'(1);
                scan_sym <= '0;
                run_cnt  <= '0;
                run_ofs  <= '0;
                run_code <= '0;
            end else if (busy) begin
                if (last_sym) begin
                    scan_sym <= '0;
                    run_cnt  <= '0;
                    run_ofs  <= run_ofs + cnt_next;
                    // Next first code is (first + count) doubled
                    run_code <= (run_code + inflate_pkg::code_t'(cnt_next)) << 1;
                    scan_len <= scan_len + 1'b1;
                    if (scan_len == inflate_pkg::len_t'(inflate_pkg::max_code_len)) begin
                        busy        <= 1'b0;
                        tables_done <= 1'b1;
                    end
                end else begin
                    scan_sym <= scan_sym + 1'b1;
                    run_cnt  <= cnt_next;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busy) begin
            if (hit) begin
                huff_table.symbols[run_ofs + run_cnt] <= scan_sym;
            end
            if (last_sym) begin
                huff_table.count[scan_len]  <= cnt_next;
                huff_table.first[scan_len]  <= run_code;
                huff_table.offset[scan_len] <= run_ofs;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) tables_done |=> !tables_done)
        else $error("huff_table_gen: tables_done longer than one cycle");

endmodule

// ==== hdl/huff_decoder.sv ====
module huff_decoder (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     active,
    input  logic [7:0]               data_in,
    input  logic                     data_in_vld,
    input  inflate_pkg::huff_table_s huff_table,
    input  logic                     beat_rdy,
    output logic                     in_rdy,
    output inflate_pkg::sym_beat_s   beat
);

    logic [7:0]         shreg;
    logic [3:0]         bit_cnt;
    inflate_pkg::code_t code;
    inflate_pkg::len_t  cur_len;

    inflate_pkg::len_t  next_len;
    inflate_pkg::code_t next_code;
    inflate_pkg::code_t diff;
    inflate_pkg::sym_t  sorted_idx;
    logic               load;
    logic               shift_en;
    logic               hit;

    assign in_rdy = active && (bit_cnt == 4'd0);
    assign load   = in_rdy && data_in_vld;

    // Stall while a beat waits on the packer
    assign shift_en = active && (bit_cnt != 4'd0) && (!beat.valid || beat_rdy);

    // Codes arrive MSB first, one stream bit per cycle
    assign next_len   = cur_len + 1'b1;
    assign next_code  = {code[5:0], shreg[0]};
    assign diff       = next_code - huff_table.first[next_len];
    assign hit        = diff < inflate_pkg::code_t'(huff_table.count[next_len]);
    assign sorted_idx = huff_table.offset[next_len] + inflate_pkg::sym_t'(diff);

    always_ff @(posedge clk) begin
        if (load) begin
            shreg <= data_in;
        end else if (shift_en) begin
            shreg <= shreg >> 1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt <= '0;
            code    <= '0;
            cur_len <= '0;
            beat    <= '0;
        end else if (!active) begin
            bit_cnt <= '0;
            code    <= '0;
            cur_len <= '0;
            beat    <= '0;
        end else begin
            if (beat.valid && beat_rdy) begin
                beat.valid <= 1'b0;
            end
            if (load) begin
                bit_cnt <= 4'd8;
            end else if (shift_en) begin
                bit_cnt <= bit_cnt - 1'b1;
                if (hit || (next_len == inflate_pkg::len_t'(inflate_pkg::max_code_len))) begin
                    code    <= '0;
                    cur_len <= '0;
                end else begin
                    code    <= next_code;
                    cur_len <= next_len;
                end
                if (hit) begin
                    beat.valid <= 1'b1;
                    beat.sym   <= huff_table.symbols[sorted_idx];
                end
            end
        end
    end

    // Stream and table must agree before the longest code runs out
    assert property (@(posedge clk) disable iff (!rst_n)
        (shift_en && (next_len == inflate_pkg::len_t'(inflate_pkg::max_code_len))) |-> hit)
        else $error("huff_decoder: no match at maximum code length");

endmodule

// ==== hdl/nibble_packer.sv ====
module nibble_packer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   clear,
    input  inflate_pkg::sym_beat_s beat,
    input  logic                   data_out_rdy,
    output logic                   beat_rdy,
    output logic [7:0]             data_out,
    output logic                   data_out_vld
);

    logic half;
    logic take;

    assign beat_rdy = !(data_out_vld && !data_out_rdy);
    assign take     = beat.valid && beat_rdy
                      && (beat.sym != inflate_pkg::sym_t'(inflate_pkg::sym_end));

    // Low nibble first
    always_ff @(posedge clk) begin
        if (take) begin
            if (half) begin
                data_out[7:4] <= beat.sym[3:0];
            end else begin
                data_out[3:0] <= beat.sym[3:0];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            half         <= 1'b0;
            data_out_vld <= 1'b0;
        end else if (clear) begin
            half         <= 1'b0;
            data_out_vld <= 1'b0;
        end else begin
            if (take) begin
                half <= !half;
            end
            if (take && half) begin
                data_out_vld <= 1'b1;
            end else if (data_out_rdy) begin
                data_out_vld <= 1'b0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (data_out_vld && !data_out_rdy && !clear) |=> (data_out_vld && $stable(data_out)))
        else $error("nibble_packer: output byte changed while stalled");

endmodule

// ==== hdl/inflate_top.sv ====
module inflate_top (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  logic       exit,
    input  logic [7:0] data_in,
    input  logic       data_in_vld,
    output logic       data_in_rdy,
    output logic [7:0] data_out,
    output logic       data_out_vld,
    input  logic       data_out_rdy,
    output logic       decode_finish
);

    inflate_pkg::phase_e      phase;
    inflate_pkg::phase_e      phase_nxt;

    logic                     unp_rdy;
    logic                     len_valid;
    inflate_pkg::len_t        len;
    logic                     header_done;
    inflate_pkg::huff_table_s huff_table;
    logic                     tables_done;
    logic                     dec_rdy;
    inflate_pkg::sym_beat_s   beat;
    logic                     beat_rdy;
    logic                     end_accept;

    assign end_accept = beat.valid && beat_rdy
                        && (beat.sym == inflate_pkg::sym_t'(inflate_pkg::sym_end));

    always_comb begin
        phase_nxt = phase;
        case (phase)
            inflate_pkg::phase_idle: begin
                if (start) begin
                    phase_nxt = inflate_pkg::phase_header;
                end
            end
            inflate_pkg::phase_header: begin
                if (header_done) begin
                    phase_nxt = inflate_pkg::phase_build;
                end
            end
            inflate_pkg::phase_build: begin
                if (tables_done) begin
                    phase_nxt = inflate_pkg::phase_decode;
                end
            end
            inflate_pkg::phase_decode: begin
                if (end_accept || exit) begin
                    phase_nxt = inflate_pkg::phase_idle;
                end
            end
            default: phase_nxt = inflate_pkg::phase_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= inflate_pkg::phase_idle;
        end else begin
            phase <= phase_nxt;
        end
    end

    // Input bytes go to whichever block owns the current phase
    always_comb begin
        case (phase)
            inflate_pkg::phase_header: data_in_rdy = unp_rdy;
            inflate_pkg::phase_decode: data_in_rdy = dec_rdy;
            default:                   data_in_rdy = 1'b0;
        endcase
    end

    assign decode_finish = (phase == inflate_pkg::phase_decode)
                           && (phase_nxt == inflate_pkg::phase_idle);

    length_unpacker i_unpacker (
        .clk         (clk),
        .rst_n       (rst_n),
        .active      (phase == inflate_pkg::phase_header),
        .data_in     (data_in),
        .data_in_vld (data_in_vld),
        .in_rdy      (unp_rdy),
        .len_valid   (len_valid),
        .len         (len),
        .header_done (header_done)
    );

    huff_table_gen i_table_gen (
        .clk         (clk),
        .rst_n       (rst_n),
        .len_valid   (len_valid),
        .len         (len),
        .header_done (header_done),
        .huff_table  (huff_table),
        .tables_done (tables_done)
    );

    huff_decoder i_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .active      (phase == inflate_pkg::phase_decode),
        .data_in     (data_in),
        .data_in_vld (data_in_vld),
        .huff_table  (huff_table),
        .beat_rdy    (beat_rdy),
        .in_rdy      (dec_rdy),
        .beat        (beat)
    );

    nibble_packer i_packer (
        .clk          (clk),
        .rst_n        (rst_n),
        .clear        (phase == inflate_pkg::phase_idle),
        .beat         (beat),
        .data_out_rdy (data_out_rdy),
        .beat_rdy     (beat_rdy),
        .data_out     (data_out),
        .data_out_vld (data_out_vld)
    );

    // No finish pulse while the engine is idle
    assert property (@(posedge clk) disable iff (!rst_n)
        (phase == inflate_pkg::phase_idle) |-> !decode_finish)
        else $error("inflate_top: decode_finish high in phase_idle");

endmodule

// ==== tests/tb_inflate.sv ====
module tb_inflate;

    logic       clk = 1'b0;
    logic       rst_n = 1'b0;
    logic       start = 1'b0;
    logic       exit = 1'b0;
    logic [7:0] data_in = 8'h00;
    logic       data_in_vld = 1'b0;
    logic       data_out_rdy = 1'b1;
    logic       data_in_rdy;
    logic [7:0] data_out;
    logic       data_out_vld;
    logic       decode_finish;

    int         lens [17];
    int         codes [17];
    logic [7:0] stream [64];
    int         bit_pos;
    int         stream_len;
    logic [3:0] pend_nib;
    bit         have_nib;

    logic [7:0] exp_mem [256];
    logic [7:0] exp_head;
    int         exp_wr = 0;
    int         exp_rd = 0;
    logic       out_fire = 1'b0;
    logic       fin_fire = 1'b0;
    logic       out_now;
    int         finish_cnt = 0;
    int         fin_base = 0;

    bit         pre_start = 1'b1;
    bit         after_exit = 1'b0;
    bit         stream_sent = 1'b0;
    bit         rand_rdy = 1'b0;
    int         cycle = 0;
    int         deadline = 200;
    int         err_cnt = 0;
    int         test_cnt = 0;
    int         fail_tests = 0;

    inflate_top i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .exit          (exit),
        .data_in       (data_in),
        .data_in_vld   (data_in_vld),
        .data_in_rdy   (data_in_rdy),
        .data_out      (data_out),
        .data_out_vld  (data_out_vld),
        .data_out_rdy  (data_out_rdy),
        .decode_finish (decode_finish)
    );

    always #50 clk = !clk;

    always @(posedge clk) begin
        #10;
        if (rand_rdy) begin
            data_out_rdy = 1'($urandom);
        end else begin
            data_out_rdy = 1'b1;
        end
    end

    // Output side bookkeeping, captured where the outputs are settled
    always @(negedge clk) begin
        out_fire <= data_out_vld && data_out_rdy;
        fin_fire <= decode_finish;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (out_fire) begin
            exp_rd <= exp_rd + 1;
        end
        if (fin_fire) begin
            finish_cnt <= finish_cnt + 1;
        end
        if (cycle > deadline) begin
            $display("Timeout: the current test ran past its cycle budget at %0t", $time);
            $display("Test failures found");
            $finish;
        end
    end

    assign exp_head = exp_mem[exp_rd];
    assign out_now  = data_out_vld && data_out_rdy;

    task automatic report_fail(input string msg);
        err_cnt++;
        $display("[FAIL] %0t: %s", $time, msg);
    endtask

    assert property (@(negedge clk)
        pre_start |-> (!data_in_rdy && !data_out_vld && !decode_finish))
        else report_fail("outputs not idle before the first start");

    assert property (@(negedge clk) disable iff (!rst_n)
        out_now |-> ((exp_rd < exp_wr) && (data_out == exp_head)))
        else report_fail("output byte wrong or unexpected");

    assert property (@(negedge clk) disable iff (!rst_n || exit)
        (data_out_vld && !data_out_rdy) |=> (data_out_vld && $stable(data_out)))
        else report_fail("output byte not held under back-pressure");

    // Every expected byte is out or leaving when the block ends
    assert property (@(negedge clk) disable iff (!rst_n || exit)
        decode_finish |-> (stream_sent && (finish_cnt == fin_base)
                           && (exp_rd + int'(out_now) == exp_wr)))
        else report_fail("decode_finish early, repeated or with a wrong byte count");

    assert property (@(negedge clk)
        after_exit |-> (!data_in_rdy && !data_out_vld && !decode_finish))
        else report_fail("engine still active after exit");

    task automatic put_bits(input int value, input int n, input bit msb_first);
        int k;
        for (int i = 0; i < n; i++) begin
            k = msb_first ? n - 1 - i : i;
            stream[bit_pos / 8][bit_pos % 8] = value[k];
            bit_pos++;
        end
    endtask

    task automatic set_lens_a();
        for (int s = 0; s < 16; s++) begin
            lens[s] = 5;
        end
        lens[16] = 1;
    endtask

    // Complete but uneven, symbols 13 and 14 unused
    task automatic set_lens_b();
        lens = '{2, 2, 3, 5, 4, 4, 5, 5, 6, 6, 6, 7, 7, 0, 0, 5, 4};
    endtask

    // Header bytes, then canonical codes for the data part
    task automatic begin_stream();
        int cnt [8];
        int nxt [8];
        int code;
        for (int i = 0; i < 64; i++) begin
            stream[i] = 8'h00;
        end
        foreach (cnt[l]) begin
            cnt[l] = 0;
        end
        bit_pos  = 0;
        have_nib = 1'b0;
        for (int s = 0; s < 17; s++) begin
            put_bits(lens[s], 3, 1'b0);
            if (lens[s] != 0) begin
                cnt[lens[s]]++;
            end
        end
        bit_pos = 56;
        code = 0;
        for (int l = 1; l < 8; l++) begin
            nxt[l] = code;
            code = (code + cnt[l]) << 1;
        end
        for (int s = 0; s < 17; s++) begin
            if (lens[s] != 0) begin
                codes[s] = nxt[lens[s]];
                nxt[lens[s]]++;
            end
        end
    endtask

    task automatic add_nibble(input int n);
        put_bits(codes[n], lens[n], 1'b1);
        if (have_nib) begin
            exp_mem[exp_wr] = {n[3:0], pend_nib};
            exp_wr++;
        end else begin
            pend_nib = n[3:0];
        end
        have_nib = !have_nib;
    endtask

    task automatic add_random_nibbles(input int num);
        int n;
        for (int i = 0; i < num; i++) begin
            do begin
                n = $urandom % 16;
            end while (lens[n] == 0);
            add_nibble(n);
        end
    endtask

    task automatic end_stream();
        put_bits(codes[16], lens[16], 1'b1);
        stream_len = (bit_pos + 7) / 8;
    endtask

    task automatic start_block();
        fin_base    = finish_cnt;
        stream_sent = 1'b0;
        deadline    = cycle + 200 + 20 * stream_len;
        start = 1'b1;
        @(posedge clk);
        #10;
        start = 1'b0;
    endtask

    task automatic send_bytes(input int first, input int last);
        for (int i = first; i < last; i++) begin
            data_in     = stream[i];
            data_in_vld = 1'b1;
            @(negedge clk);
            while (!data_in_rdy) @(negedge clk);
            @(posedge clk);
            #10;
        end
        data_in_vld = 1'b0;
    endtask

    task automatic run_block();
        start_block();
        send_bytes(0, stream_len);
        stream_sent = 1'b1;
        @(negedge clk);
        while (!decode_finish) @(negedge clk);
        @(posedge clk);
        #10;
    endtask

    task automatic fixed_set_a_block();
        set_lens_a();
        begin_stream();
        for (int i = 0; i < 16; i++) begin
            add_nibble((i * 7 + 3) % 16);
        end
        end_stream();
        run_block();
    endtask

    task automatic close_test(input string name, input int err_before);
        test_cnt++;
        if (err_cnt == err_before) begin
            $display("test %0d %s: ok", test_cnt, name);
        end else begin
            fail_tests++;
            $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err_before);
        end
    endtask

    initial begin
        int err_before;
        void'($urandom(32'h4f53));
        repeat (2) @(posedge clk);
        #10;
        rst_n = 1'b1;

        err_before = err_cnt;
        repeat (5) @(posedge clk);
        #10;
        close_test("idle after reset", err_before);

        err_before = err_cnt;
        pre_start = 1'b0;
        fixed_set_a_block();
        close_test("set A fixed sequence", err_before);

        err_before = err_cnt;
        set_lens_b();
        begin_stream();
        add_random_nibbles(40);
        end_stream();
        run_block();
        close_test("set B random nibbles", err_before);

        err_before = err_cnt;
        rand_rdy = 1'b1;
        begin_stream();
        add_random_nibbles(30);
        end_stream();
        run_block();
        rand_rdy = 1'b0;
        close_test("random output back-pressure", err_before);

        err_before = err_cnt;
        set_lens_a();
        begin_stream();
        for (int i = 0; i < 7; i++) begin
            add_nibble(15 - 2 * i);
        end
        end_stream();
        run_block();
        close_test("odd nibble count", err_before);

        // Abort halfway through the data bytes
        err_before = err_cnt;
        set_lens_b();
        begin_stream();
        add_random_nibbles(40);
        end_stream();
        start_block();
        send_bytes(0, 7 + (stream_len - 7) / 2);
        repeat (3) @(posedge clk);
        #10;
        exit = 1'b1;
        @(posedge clk);
        #10;
        exit = 1'b0;
        @(posedge clk);
        #10;
        after_exit = 1'b1;
        repeat (10) @(posedge clk);
        #10;
        after_exit = 1'b0;
        exp_wr = exp_rd;
        fixed_set_a_block();
        close_test("exit and restart", err_before);

        $display("tests run: %0d, tests failed: %0d, check errors: %0d",
                 test_cnt, fail_tests, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
hdl/inflate_pkg.sv
hdl/length_unpacker.sv
hdl/huff_table_gen.sv
hdl/huff_decoder.sv
hdl/nibble_packer.sv
hdl/inflate_top.sv
tests/tb_inflate.sv

// ==== Makefile ====
TOP = tb_inflate

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f sources.f --Mdir obj_dir -o sim
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
